// ==== logic/mmu_defs.svh ====
// Size and width constants for the Sv32 translation unit
// Include wherever TLB geometry or address widths are needed
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// log2 of the TLB entry count
`define TLB_INDEX_WIDTH 2
`define TLB_ENTRIES (1 << `TLB_INDEX_WIDTH)

// Sv32 page number and physical address widths
`define VPN_WIDTH 20
`define PPN_WIDTH 22
`define PADDR_WIDTH 34

`endif

// ==== logic/rvTypes.sv ====
// Architectural types of the RV32 core seen by the translation unit
// Privilege levels, access kinds, the satp CSR and page numbers
`include "mmu_defs.svh"

package RvTypes;

    typedef enum logic [1:0] {
        PrivilegeUser       = 2'b00,
        PrivilegeSupervisor = 2'b01,
        PrivilegeMachine    = 2'b11
    } Privilege;

    typedef enum logic [1:0] {
        AccessInstruction = 2'b00,
        AccessLoad        = 2'b01,
        AccessStore       = 2'b10
    } MemoryAccessType;

    typedef enum logic {
        ModeBare = 1'b0,
        ModeSv32 = 1'b1
    } AddressTranslationMode;

    typedef logic [`PPN_WIDTH-1:0] physical_page_number_t;

    // Two 10-bit levels of the Sv32 virtual page number
    typedef struct packed {
        logic [`VPN_WIDTH/2-1:0] vpn1;
        logic [`VPN_WIDTH/2-1:0] vpn0;
    } virtual_page_number_t;

    typedef struct packed {
        AddressTranslationMode mode;
        logic [8:0] asid;
        physical_page_number_t ppn;
    } csr_satp_t;

endpackage

// ==== logic/tlbTypes.sv ====
// Page-table and TLB storage types for the Sv32 translation unit
// Shared by the TLB, the page walker and the walker bus checks
package TlbTypes;

    // Sv32 PTE flag bits, bit 7 down to bit 0
    typedef struct packed {
        logic dirty;
        logic accessed;
        logic global;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } PteFlags;

    typedef struct packed {
        RvTypes::physical_page_number_t ppn;
        logic [1:0] reserved;
        PteFlags flags;
    } Pte;

    typedef struct packed {
        logic valid;
        logic fault;
        PteFlags flags;
        RvTypes::physical_page_number_t pageNumber;
    } TlbEntry;

    typedef enum logic [2:0] {
        WalkIdle,
        WalkReadL1,
        WalkReadL0,
        WalkWriteBack,
        WalkDone
    } WalkState;

endpackage

// ==== logic/walkIf.sv ====
// Walk request and result channel between the front end and the walker
// start is a one-cycle pulse, done answers it once with entry valid
`timescale 1ns/100ps

interface walkIf;
    import RvTypes::*;
    import TlbTypes::*;

    logic start;
    virtual_page_number_t vpn;
    MemoryAccessType accessType;
    physical_page_number_t satpPpn;
    logic busy;
    logic done;
    TlbEntry entry;

    modport requester (output start, vpn, accessType, satpPpn, input busy, done, entry);
    modport walker (input start, vpn, accessType, satpPpn, output busy, done, entry);

endinterface

// ==== logic/flipFlopCam.sv ====
// Register-based CAM holding the TLB entries
// Lookup is combinational, a write lands on the next clock
`timescale 1ns/100ps
`include "mmu_defs.svh"

module flipFlopCam (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  RvTypes::virtual_page_number_t readKey,
    output logic hit,
    output logic [`TLB_INDEX_WIDTH-1:0] readIndex,
    output TlbTypes::TlbEntry readValue,
    input  logic writeEnable,
    input  logic [`TLB_INDEX_WIDTH-1:0] writeIndex,
    input  RvTypes::virtual_page_number_t writeKey,
    input  TlbTypes::TlbEntry writeValue
);
    import RvTypes::*;
    import TlbTypes::*;

    logic [`TLB_ENTRIES-1:0] slotValid;
    virtual_page_number_t keyArray [`TLB_ENTRIES];
    TlbEntry valueArray [`TLB_ENTRIES];

    // Parallel compare, at most one slot matches
    always_comb begin
        hit = 1'b0;
        readIndex = '0;
        readValue = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (slotValid[i] && keyArray[i] == readKey) begin
                hit = 1'b1;
                readIndex = i[`TLB_INDEX_WIDTH-1:0];
                readValue = valueArray[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            slotValid <= '0;
        end else if (writeEnable) begin
            slotValid[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            keyArray[writeIndex] <= writeKey;
            valueArray[writeIndex] <= writeValue;
        end
    end

endmodule

// ==== logic/tlbArray.sv ====
// Fully associative TLB with Sv32 permission checks
// Lookup is combinational, refills go to a round-robin victim slot
// A store to a clean entry reads as a miss so the walker sets D
`timescale 1ns/100ps
`include "mmu_defs.svh"

module tlbArray (
    input  logic clk,
    input  logic rst,
    input  logic readEnable,
    input  RvTypes::virtual_page_number_t readKey,
    input  RvTypes::MemoryAccessType readAccessType,
    output logic hit,
    output logic fault,
    output RvTypes::physical_page_number_t readValue,
    input  logic writeEnable,
    input  RvTypes::virtual_page_number_t writeKey,
    input  TlbTypes::TlbEntry writeValue,
    input  RvTypes::csr_satp_t csrSatp,
    input  RvTypes::Privilege csrPrivilege,
    input  logic csrSum,
    input  logic csrMxr,
    input  logic invalidate
);
    import RvTypes::*;
    import TlbTypes::*;

    function automatic logic isFault(TlbEntry entry, MemoryAccessType accessType,
                                     Privilege privilege, logic sum, logic mxr);
        if (entry.fault) begin
            return 1'b1;
        end
        if (privilege == PrivilegeSupervisor && !sum && entry.flags.user) begin
            return 1'b1;
        end
        if (privilege == PrivilegeUser && !entry.flags.user) begin
            return 1'b1;
        end
        case (accessType)
            AccessInstruction: return !entry.flags.execute;
            AccessLoad:        return !entry.flags.read && !(mxr && entry.flags.execute);
            AccessStore:       return !entry.flags.write;
            default:           return 1'b1;
        endcase
    endfunction

    logic [`TLB_INDEX_WIDTH-1:0] victimIndex;
    logic [`TLB_INDEX_WIDTH-1:0] nextVictim;
    logic [`TLB_INDEX_WIDTH-1:0] camIndex;
    logic camHit;
    TlbEntry camValue;
    logic translating;
    logic entryFault;
    logic needsDirty;

    flipFlopCam cam (
        .clk,
        .rst,
        .clear(invalidate),
        .readKey,
        .hit(camHit),
        .readIndex(camIndex),
        .readValue(camValue),
        .writeEnable,
        .writeIndex(victimIndex),
        .writeKey,
        .writeValue
    );

    assign translating = csrPrivilege != PrivilegeMachine && csrSatp.mode == ModeSv32;
    assign entryFault = isFault(camValue, readAccessType, csrPrivilege, csrSum, csrMxr);
    assign needsDirty = readAccessType == AccessStore && !camValue.flags.dirty;

    always_comb begin
        if (translating) begin
            hit = readEnable && camHit && !(needsDirty && !entryFault);
            fault = readEnable && camHit && entryFault;
            readValue = camValue.pageNumber;
        end else begin
            hit = readEnable;
            fault = 1'b0;
            readValue = {{(`PPN_WIDTH - `VPN_WIDTH){1'b0}}, readKey};
        end
    end

    // Aim the refill at the matched slot when only D is missing
    always_comb begin
        if (readEnable && translating && camHit && needsDirty && !entryFault) begin
            nextVictim = camIndex;
        end else if (writeEnable) begin
            nextVictim = victimIndex + 1'b1;
        end else begin
            nextVictim = victimIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            victimIndex <= '0;
        end else begin
            victimIndex <= nextVictim;
        end
    end

endmodule

// ==== logic/pageWalker.sv ====
// Two-level Sv32 page-table walker acting as a Wishbone classic master
// Reads the level-1 and level-0 PTEs and writes A and D back when needed
// Every bus access drops wbCyc for at least one cycle after its wbAck
`timescale 1ns/100ps
`include "mmu_defs.svh"

module pageWalker (
    input  logic clk,
    input  logic rst,
    walkIf.walker walk,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [`PADDR_WIDTH-1:0] wbAdr,
    output logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic wbAck
);
    import RvTypes::*;
    import TlbTypes::*;

    function automatic TlbEntry makeEntry(logic isFaulty, PteFlags flags,
                                          physical_page_number_t ppn);
        TlbEntry entry;
        entry.valid = 1'b1;
        entry.fault = isFaulty;
        entry.flags = flags;
        entry.pageNumber = ppn;
        return entry;
    endfunction

    WalkState state;
    logic cycReg;
    logic [`PADDR_WIDTH-1:0] adrReg;
    Pte pteReg;
    TlbEntry entryReg;
    virtual_page_number_t vpnReg;
    MemoryAccessType accessReg;
    Pte readPte;
    PteFlags leafFlags;
    logic pteInvalid;
    logic isLeaf;
    logic accessDone;

    assign readPte = wbDatR;
    assign accessDone = cycReg && wbAck;
    // W without R is a reserved encoding
    assign pteInvalid = !readPte.flags.valid || (readPte.flags.write && !readPte.flags.read);
    assign isLeaf = readPte.flags.read || readPte.flags.execute;

    // D is only set when the page is writable
    always_comb begin
        leafFlags = readPte.flags;
        leafFlags.accessed = 1'b1;
        if (accessReg == AccessStore && readPte.flags.write) begin
            leafFlags.dirty = 1'b1;
        end
    end

    assign wbCyc = cycReg;
    assign wbStb = cycReg;
    assign wbWe = state == WalkWriteBack;
    assign wbAdr = adrReg;
    assign wbDatW = pteReg;

    assign walk.busy = state != WalkIdle;
    assign walk.done = state == WalkDone;
    assign walk.entry = entryReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WalkIdle;
            cycReg <= 1'b0;
        end else begin
            case (state)
                WalkIdle: begin
                    if (walk.start) begin
                        state <= WalkReadL1;
                    end
                end
                WalkReadL1: begin
                    if (!cycReg) begin
                        cycReg <= 1'b1;
                    end else if (wbAck) begin
                        cycReg <= 1'b0;
                        // Superpage leaves are not supported and end as a fault
                        state <= (pteInvalid || isLeaf) ? WalkDone : WalkReadL0;
                    end
                end
                WalkReadL0: begin
                    if (!cycReg) begin
                        cycReg <= 1'b1;
                    end else if (wbAck) begin
                        cycReg <= 1'b0;
                        if (pteInvalid || !isLeaf || leafFlags == readPte.flags) begin
                            state <= WalkDone;
                        end else begin
                            state <= WalkWriteBack;
                        end
                    end
                end
                WalkWriteBack: begin
                    if (!cycReg) begin
                        cycReg <= 1'b1;
                    end else if (wbAck) begin
                        cycReg <= 1'b0;
                        state <= WalkDone;
                    end
                end
                default: state <= WalkIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WalkIdle && walk.start) begin
            vpnReg <= walk.vpn;
            accessReg <= walk.accessType;
            adrReg <= {walk.satpPpn, walk.vpn.vpn1, 2'b00};
        end
        if (state == WalkReadL1 && accessDone) begin
            adrReg <= {readPte.ppn, vpnReg.vpn0, 2'b00};
            entryReg <= makeEntry(1'b1, readPte.flags, readPte.ppn);
        end
        if (state == WalkReadL0 && accessDone) begin
            // Write-back reuses the level-0 address
            pteReg <= {readPte.ppn, readPte.reserved, leafFlags};
            entryReg <= makeEntry(pteInvalid || !isLeaf, leafFlags, readPte.ppn);
        end
    end

endmodule

// ==== logic/mmuFront.sv ====
// Request sequencer of the translation unit
// Looks up the TLB on transfer, walks on a miss, then refills and re-reads
// One request in flight, responses are registered
`timescale 1ns/100ps

module mmuFront (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    output logic reqReady,
    input  RvTypes::virtual_page_number_t reqVaddrPage,
    input  RvTypes::MemoryAccessType reqAccessType,
    output logic respValid,
    output RvTypes::physical_page_number_t respPpn,
    output logic respFault,
    input  RvTypes::csr_satp_t csrSatp,
    walkIf.requester walk,
    output logic tlbLookup,
    output RvTypes::virtual_page_number_t tlbKey,
    output RvTypes::MemoryAccessType tlbAccessType,
    input  logic tlbHit,
    input  logic tlbFault,
    input  RvTypes::physical_page_number_t tlbValue,
    output logic tlbWrite,
    output TlbTypes::TlbEntry tlbWriteValue
);
    import RvTypes::*;

    typedef enum logic [1:0] {
        FrontIdle,
        FrontWalk,
        FrontReread
    } FrontState;

    FrontState state;
    virtual_page_number_t pendingVpn;
    MemoryAccessType pendingAccess;
    logic startPulse;
    logic transfer;

    assign reqReady = state == FrontIdle && !respValid && !walk.busy;
    assign transfer = reqValid && reqReady;

    // Live request while idle, held request otherwise
    assign tlbLookup = transfer || state == FrontReread;
    assign tlbKey = (state == FrontIdle) ? reqVaddrPage : pendingVpn;
    assign tlbAccessType = (state == FrontIdle) ? reqAccessType : pendingAccess;
    assign tlbWrite = state == FrontWalk && walk.done;
    assign tlbWriteValue = walk.entry;

    assign walk.start = startPulse;
    assign walk.vpn = pendingVpn;
    assign walk.accessType = pendingAccess;
    assign walk.satpPpn = csrSatp.ppn;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FrontIdle;
            respValid <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            respValid <= 1'b0;
            startPulse <= 1'b0;
            case (state)
                FrontIdle: begin
                    if (transfer && (tlbHit || tlbFault)) begin
                        respValid <= 1'b1;
                    end else if (transfer) begin
                        startPulse <= 1'b1;
                        state <= FrontWalk;
                    end
                end
                FrontWalk: begin
                    if (walk.done) begin
                        state <= FrontReread;
                    end
                end
                default: begin
                    respValid <= 1'b1;
                    state <= FrontIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            pendingVpn <= reqVaddrPage;
            pendingAccess <= reqAccessType;
        end
        // A re-read that still misses can only come from a broken entry
        if (tlbLookup) begin
            respPpn <= tlbValue;
            respFault <= tlbFault || !tlbHit;
        end
    end

endmodule

// ==== logic/translationUnit.sv ====
// Top level of the Sv32 address-translation unit
// Request and response handshake, CSR inputs and a Wishbone classic master
`timescale 1ns/100ps
`include "mmu_defs.svh"

module translationUnit (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    output logic reqReady,
    input  RvTypes::virtual_page_number_t reqVaddrPage,
    input  RvTypes::MemoryAccessType reqAccessType,
    output logic respValid,
    output RvTypes::physical_page_number_t respPpn,
    output logic respFault,
    input  RvTypes::csr_satp_t csrSatp,
    input  RvTypes::Privilege csrPrivilege,
    input  logic csrSum,
    input  logic csrMxr,
    input  logic invalidate,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output logic [`PADDR_WIDTH-1:0] wbAdr,
    output logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic wbAck
);
    import RvTypes::*;
    import TlbTypes::*;

    logic tlbLookup;
    logic tlbHit;
    logic tlbFault;
    logic tlbWrite;
    virtual_page_number_t tlbKey;
    MemoryAccessType tlbAccessType;
    physical_page_number_t tlbValue;
    TlbEntry tlbWriteValue;

    walkIf walkBus ();

    mmuFront front (
        .clk, .rst,
        .reqValid, .reqReady, .reqVaddrPage, .reqAccessType,
        .respValid, .respPpn, .respFault,
        .csrSatp,
        .walk(walkBus.requester),
        .tlbLookup, .tlbKey, .tlbAccessType,
        .tlbHit, .tlbFault, .tlbValue,
        .tlbWrite, .tlbWriteValue
    );

    // The same key serves lookup and refill
    tlbArray tlb (
        .clk, .rst,
        .readEnable(tlbLookup), .readKey(tlbKey), .readAccessType(tlbAccessType),
        .hit(tlbHit), .fault(tlbFault), .readValue(tlbValue),
        .writeEnable(tlbWrite), .writeKey(tlbKey), .writeValue(tlbWriteValue),
        .csrSatp, .csrPrivilege, .csrSum, .csrMxr,
        .invalidate
    );

    pageWalker walker (
        .clk, .rst,
        .walk(walkBus.walker),
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
        .wbDatR, .wbAck
    );

endmodule

// ==== verif/pageTableModel.sv ====
// Wishbone classic slave memory holding the Sv32 page tables for the testbench
// Covers two 4 KiB pages selected by address bit 12, with random wait states
`timescale 1ns/100ps
`include "mmu_defs.svh"

module pageTableModel (
    input  logic clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [`PADDR_WIDTH-1:0] wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic wbAck
);
    logic [31:0] mem [0:2047];
    logic [1:0] waitLeft;

    // Root table page and level-0 table page
    function automatic logic [10:0] wordIndex(logic [`PADDR_WIDTH-1:0] adr);
        return {adr[12], adr[11:2]};
    endfunction

    task automatic writeWord(input logic [`PADDR_WIDTH-1:0] adr, input logic [31:0] data);
        mem[wordIndex(adr)] = data;
    endtask

    function automatic logic [31:0] readWord(input logic [`PADDR_WIDTH-1:0] adr);
        return mem[wordIndex(adr)];
    endfunction

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 32'h0;
        end
    end

    assign wbDatR = mem[wordIndex(wbAdr)];

    always @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            waitLeft <= 2'd0;
        end else if (wbAck) begin
            wbAck <= 1'b0;
            waitLeft <= 2'($urandom % 4);
        end else if (wbCyc && wbStb) begin
            if (waitLeft == 2'd0) begin
                wbAck <= 1'b1;
                if (wbWe) begin
                    mem[wordIndex(wbAdr)] <= wbDatW;
                end
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

endmodule

// ==== verif/tbTranslationUnit.sv ====
// Testbench for the Sv32 translation unit
// Builds page tables in the memory model, issues requests and checks each response
// against a reference translation worked out from the page-table contents
`timescale 1ns/100ps
`include "mmu_defs.svh"

module tbTranslationUnit;
    import RvTypes::*;
    import TlbTypes::*;

    localparam physical_page_number_t RootPpn = 22'h100;
    localparam physical_page_number_t LeafTablePpn = 22'h101;
    localparam int ExpectHit = 0;
    localparam int ExpectWalk = 1;

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    logic reqReady;
    virtual_page_number_t reqVaddrPage;
    MemoryAccessType reqAccessType;
    logic respValid;
    physical_page_number_t respPpn;
    logic respFault;
    csr_satp_t csrSatp;
    Privilege csrPrivilege;
    logic csrSum;
    logic csrMxr;
    logic invalidate;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [`PADDR_WIDTH-1:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic wbAck;
    int issuedCount = 0;
    int cycleCount = 0;
    int writeCount = 0;
    int errorCount = 0;
    int writesBefore;
    Pte checkPte;
    logic requestOpen = 1'b0;
    logic ackTaken = 1'b0;
    logic [`PADDR_WIDTH-1:0] heldAdr;
    logic heldWe;
    logic [31:0] heldDat;

    translationUnit uut (.*);

    pageTableModel pageTables (
        .clk, .rst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (!rst && wbCyc && wbAck && wbWe) begin
            writeCount++;
        end
    end

    // Budget grows with every request issued
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > (issuedCount + 1) * 200) begin
            errorCount++;
            $display("Timeout: no progress after %0d cycles at time %0t", cycleCount, $time);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("Error at time %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // Wishbone classic rules on the walker port, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            assert (wbStb === wbCyc)
                else reportFailure("wbStb does not follow wbCyc");
            // Both table pages share every address bit above bit 12
            assert (!wbCyc || wbAdr[`PADDR_WIDTH-1:13] == RootPpn[`PPN_WIDTH-1:1])
                else reportFailure($sformatf("walker address %h outside the tables", wbAdr));
            if (requestOpen) begin
                assert (wbCyc && wbAdr === heldAdr && wbWe === heldWe && wbDatW === heldDat)
                    else reportFailure("bus request changed before wbAck");
            end
            if (ackTaken) begin
                assert (!wbCyc)
                    else reportFailure("wbCyc still high in the cycle after wbAck");
            end
            requestOpen = wbCyc && !wbAck;
            ackTaken = wbCyc && wbAck;
            heldAdr = wbAdr;
            heldWe = wbWe;
            heldDat = wbDatW;
        end
    end

    function automatic logic isBadPte(Pte pte);
        return !pte.flags.valid || (pte.flags.write && !pte.flags.read);
    endfunction

    // Reference translation from the current page tables and CSR inputs
    function automatic void expectTranslation(input virtual_page_number_t vpn,
                                              input MemoryAccessType access,
                                              output physical_page_number_t ppn,
                                              output logic fault);
        Pte rootPte;
        Pte leafPte;
        ppn = '0;
        fault = 1'b0;
        if (csrPrivilege == PrivilegeMachine || csrSatp.mode == ModeBare) begin
            ppn = {2'b00, vpn};
            return;
        end
        rootPte = pageTables.readWord({csrSatp.ppn, vpn.vpn1, 2'b00});
        // Superpage leaves count as faults
        if (isBadPte(rootPte) || rootPte.flags.read || rootPte.flags.execute) begin
            fault = 1'b1;
            return;
        end
        leafPte = pageTables.readWord({rootPte.ppn, vpn.vpn0, 2'b00});
        if (isBadPte(leafPte) || !(leafPte.flags.read || leafPte.flags.execute)) begin
            fault = 1'b1;
            return;
        end
        ppn = leafPte.ppn;
        if (csrPrivilege == PrivilegeSupervisor && leafPte.flags.user && !csrSum) begin
            fault = 1'b1;
        end else if (csrPrivilege == PrivilegeUser && !leafPte.flags.user) begin
            fault = 1'b1;
        end else if (access == AccessInstruction) begin
            fault = !leafPte.flags.execute;
        end else if (access == AccessLoad) begin
            fault = !(leafPte.flags.read || (csrMxr && leafPte.flags.execute));
        end else begin
            fault = !leafPte.flags.write;
        end
    endfunction

    task automatic setCsr(input Privilege privilege, input logic mode, input logic sum,
                          input logic mxr);
        @(negedge clk);
        csrPrivilege = privilege;
        csrSatp = '{mode: AddressTranslationMode'(mode), asid: 9'h0, ppn: RootPpn};
        csrSum = sum;
        csrMxr = mxr;
    endtask

    task automatic flushTlb();
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
        end
        invalidate = 1'b1;
        @(negedge clk);
        invalidate = 1'b0;
    endtask

    task automatic translate(input logic [9:0] vpn1, input logic [9:0] vpn0,
                             input MemoryAccessType access, input int walkMode);
        virtual_page_number_t vpn;
        physical_page_number_t expPpn;
        logic expFault;
        int latency;
        logic busSeen;
        vpn = {vpn1, vpn0};
        expectTranslation(vpn, access, expPpn, expFault);
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
        end
        reqValid = 1'b1;
        reqVaddrPage = vpn;
        reqAccessType = access;
        issuedCount++;
        latency = 0;
        busSeen = 1'b0;
        do begin
            @(negedge clk);
            reqValid = 1'b0;
            latency++;
            if (wbCyc) begin
                busSeen = 1'b1;
            end
            assert (!reqReady)
                else reportMismatch($sformatf("vpn %h reqReady high while in flight", vpn));
        end while (!respValid);
        assert (respFault === expFault)
            else reportMismatch($sformatf("vpn %h fault %b, expected %b", vpn, respFault, expFault));
        if (!expFault) begin
            assert (respPpn === expPpn)
                else reportMismatch($sformatf("vpn %h ppn %h, expected %h", vpn, respPpn, expPpn));
        end
        if (walkMode == ExpectHit) begin
            assert (latency == 1 && !busSeen)
                else reportFailure($sformatf("vpn %h should hit but took %0d cycles", vpn, latency));
        end else begin
            assert (busSeen && latency > 1)
                else reportFailure($sformatf("vpn %h should walk but no bus cycle was seen", vpn));
        end
        @(negedge clk);
        assert (reqReady)
            else reportMismatch($sformatf("vpn %h reqReady low after the response", vpn));
    endtask

    initial begin
        void'($urandom(32'hfdede8f4));
        rst = 1'b1;
        reqValid = 1'b0;
        reqVaddrPage = '0;
        reqAccessType = AccessLoad;
        csrSatp = '{mode: ModeSv32, asid: 9'h0, ppn: RootPpn};
        csrPrivilege = PrivilegeMachine;
        csrSum = 1'b0;
        csrMxr = 1'b0;
        invalidate = 1'b0;

        // Root entries: 1 points to the leaf table, 2 is a superpage leaf, 3 stays invalid
        pageTables.writeWord({RootPpn, 10'd1, 2'b00}, {LeafTablePpn, 2'b00, 8'h01});
        pageTables.writeWord({RootPpn, 10'd2, 2'b00}, {22'h3000, 2'b00, 8'h43});
        // Leaf flags: D A G U X W R V
        pageTables.writeWord({LeafTablePpn, 10'd0, 2'b00}, {22'h2000, 2'b00, 8'hc7});
        pageTables.writeWord({LeafTablePpn, 10'd1, 2'b00}, {22'h2001, 2'b00, 8'h43});
        pageTables.writeWord({LeafTablePpn, 10'd2, 2'b00}, {22'h2002, 2'b00, 8'hdf});
        pageTables.writeWord({LeafTablePpn, 10'd3, 2'b00}, {22'h2003, 2'b00, 8'h49});
        pageTables.writeWord({LeafTablePpn, 10'd5, 2'b00}, {22'h2005, 2'b00, 8'h07});
        pageTables.writeWord({LeafTablePpn, 10'd6, 2'b00}, {22'h2006, 2'b00, 8'h47});
        for (int i = 7; i <= 10; i++) begin
            pageTables.writeWord({LeafTablePpn, 10'(i), 2'b00}, {22'h2000 + 22'(i), 2'b00, 8'hc7});
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Passthrough in Machine mode and in Bare mode
        translate(10'h3ff, 10'h155, AccessLoad, ExpectHit);
        translate(10'h001, 10'h000, AccessStore, ExpectHit);
        setCsr(PrivilegeSupervisor, ModeBare, 1'b0, 1'b0);
        translate(10'h012, 10'h034, AccessInstruction, ExpectHit);

        // Miss then hit
        setCsr(PrivilegeSupervisor, ModeSv32, 1'b0, 1'b0);
        translate(10'd1, 10'd0, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd0, AccessLoad, ExpectHit);
        translate(10'd1, 10'd0, AccessStore, ExpectHit);

        // Permission cases
        translate(10'd1, 10'd2, AccessLoad, ExpectWalk);
        setCsr(PrivilegeSupervisor, ModeSv32, 1'b1, 1'b0);
        translate(10'd1, 10'd2, AccessLoad, ExpectHit);
        setCsr(PrivilegeUser, ModeSv32, 1'b0, 1'b0);
        translate(10'd1, 10'd0, AccessLoad, ExpectHit);
        translate(10'd1, 10'd2, AccessLoad, ExpectHit);
        setCsr(PrivilegeSupervisor, ModeSv32, 1'b0, 1'b0);
        translate(10'd1, 10'd3, AccessLoad, ExpectWalk);
        setCsr(PrivilegeSupervisor, ModeSv32, 1'b0, 1'b1);
        translate(10'd1, 10'd3, AccessLoad, ExpectHit);
        translate(10'd1, 10'd3, AccessInstruction, ExpectHit);
        setCsr(PrivilegeSupervisor, ModeSv32, 1'b0, 1'b0);
        writesBefore = writeCount;
        translate(10'd1, 10'd1, AccessStore, ExpectWalk);
        assert (writeCount == writesBefore)
            else reportMismatch("read-only store caused a PTE write");
        translate(10'd1, 10'd4, AccessLoad, ExpectWalk);
        translate(10'd2, 10'd0, AccessLoad, ExpectWalk);
        translate(10'd3, 10'd0, AccessLoad, ExpectWalk);

        // Accessed bit set by a load walk
        writesBefore = writeCount;
        translate(10'd1, 10'd5, AccessLoad, ExpectWalk);
        checkPte = pageTables.readWord({LeafTablePpn, 10'd5, 2'b00});
        assert (writeCount == writesBefore + 1 && checkPte.flags.accessed)
            else reportMismatch($sformatf("A update: %0d writes, PTE %h",
                                          writeCount - writesBefore, checkPte));

        // Dirty bit set by a store to a clean cached entry
        translate(10'd1, 10'd6, AccessLoad, ExpectWalk);
        writesBefore = writeCount;
        translate(10'd1, 10'd6, AccessStore, ExpectWalk);
        checkPte = pageTables.readWord({LeafTablePpn, 10'd6, 2'b00});
        assert (writeCount == writesBefore + 1 && checkPte.flags.dirty)
            else reportMismatch($sformatf("D update: %0d writes, PTE %h",
                                          writeCount - writesBefore, checkPte));
        translate(10'd1, 10'd6, AccessStore, ExpectHit);

        // Five pages through four entries evict the first
        flushTlb();
        translate(10'd1, 10'd7, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd8, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd9, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd10, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd0, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd7, AccessLoad, ExpectWalk);

        // Everything walks again after invalidate
        flushTlb();
        translate(10'd1, 10'd0, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd7, AccessLoad, ExpectWalk);
        translate(10'd1, 10'd9, AccessLoad, ExpectWalk);

        repeat (5) @(posedge clk);
        if (errorCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== files.f ====
+incdir+logic
logic/rvTypes.sv
logic/tlbTypes.sv
logic/walkIf.sv
logic/flipFlopCam.sv
logic/tlbArray.sv
logic/pageWalker.sv
logic/mmuFront.sv
logic/translationUnit.sv
verif/pageTableModel.sv
verif/tbTranslationUnit.sv
